// File: design/dtim_defines.svh
`ifndef DTIM_DEFINES_SVH
`define DTIM_DEFINES_SVH

// The store holds 2**DTIM_DEPTH lines.
`define DTIM_DEPTH 4

// Word-select bits within one line.
`define DTIM_WIDTH 2

`define DTIM_WORDS (1 << `DTIM_WIDTH)

// Whatever is left of a word address above index and word select.
`define DTIM_TAG_BITS (30 - `DTIM_DEPTH - `DTIM_WIDTH)

`endif

// File: design/dtim_pkg.sv
`include "dtim_defines.svh"

package dtim_pkg;

  // Used for both the core port and the data-memory port.
  typedef struct packed {
    logic valid;
    logic fence;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb; // All zero for a load.
  } mem_req_t;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef logic [`DTIM_DEPTH-1:0] idx_t;
  typedef logic [`DTIM_WIDTH-1:0] wsel_t;
  typedef logic [`DTIM_TAG_BITS-1:0] tag_t;
  typedef logic [`DTIM_WORDS-1:0][31:0] line_t;
  typedef logic lock_t;

  typedef enum logic [2:0] {
    s_idle,
    s_miss,
    s_bypass,
    s_update,
    s_fence
  } state_t;

  // The captured request, already split into its address fields.
  typedef struct packed {
    logic fence;
    logic rden;
    logic wren;
    tag_t tag;
    idx_t idx;
    wsel_t wsel;
    logic [31:0] wdata;
    logic [3:0] wstrb;
  } front_t;

  typedef struct packed {
    state_t state;
    tag_t tag;
    idx_t idx;
    wsel_t wsel;
    wsel_t cnt; // Fill beat counter.
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic store;
    line_t line;
  } back_t;

endpackage

// File: design/dtim_array.sv
`timescale 1ns/1ps
`include "dtim_defines.svh"

module dtim_array import dtim_pkg::*; #(
  parameter type entry_t = logic
) (
  input logic clk,
  input logic wen,
  input idx_t waddr,
  input idx_t raddr,
  input entry_t wdata,
  output entry_t rdata
);

  entry_t mem [0:(1 << `DTIM_DEPTH)-1];

  initial begin
    for (int i = 0; i < (1 << `DTIM_DEPTH); i++) begin
      mem[i] = '0;
    end
  end

  // A read of the index being written returns the old entry.
  always @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

// File: design/dtim_ctrl.sv
`timescale 1ns/1ps
`include "dtim_defines.svh"

module dtim_ctrl import dtim_pkg::*; (
  input logic clk,
  input logic rst,
  input mem_req_t dtim_req,
  output mem_rsp_t dtim_rsp,
  output mem_req_t dmem_req,
  input mem_rsp_t dmem_rsp,
  output logic tag_wen,
  output logic line_wen,
  output logic lock_wen,
  output idx_t raddr,
  output idx_t waddr,
  output tag_t tag_wdata,
  output line_t line_wdata,
  output lock_t lock_wdata,
  input tag_t tag_rdata,
  input line_t line_rdata,
  input lock_t lock_rdata
);

  front_t f_q;
  front_t f_d;
  back_t b_q;
  back_t b_d;
  logic wen;
  logic clear;

  function automatic line_t merge_word(
    input line_t line,
    input wsel_t wsel,
    input logic [31:0] wdata,
    input logic [3:0] wstrb
  );
    line_t res;
    res = line;
    for (int i = 0; i < 4; i++) begin
      if (wstrb[i]) begin
        res[wsel][8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  always_comb begin
    f_d = f_q;
    f_d.fence = 1'b0;
    f_d.rden = 1'b0;
    f_d.wren = 1'b0;
    if (dtim_req.valid) begin
      f_d.fence = dtim_req.fence;
      f_d.wren = ~dtim_req.fence & (|dtim_req.wstrb);
      f_d.rden = ~dtim_req.fence & ~(|dtim_req.wstrb);
      f_d.tag = dtim_req.addr[31 -: `DTIM_TAG_BITS];
      f_d.idx = dtim_req.addr[`DTIM_WIDTH+2 +: `DTIM_DEPTH];
      f_d.wsel = dtim_req.addr[2 +: `DTIM_WIDTH];
      f_d.wdata = dtim_req.wdata;
      f_d.wstrb = dtim_req.wstrb;
    end
  end

  // The arrays are read in the cycle the request arrives.
  assign raddr = f_d.idx;

  always_comb begin
    b_d = b_q;
    wen = 1'b0;
    clear = 1'b0;
    waddr = b_q.idx;
    dtim_rsp.ready = 1'b0;
    dtim_rsp.rdata = '0;
    dmem_req.valid = 1'b0;
    dmem_req.fence = 1'b0;
    dmem_req.addr = {b_q.tag, b_q.idx, b_q.cnt, 2'b00};
    dmem_req.wdata = b_q.wdata;
    dmem_req.wstrb = '0;

    unique case (b_q.state)
      s_idle: begin
        if (f_q.fence) begin
          b_d.state = s_fence;
          b_d.idx = '0;
        end else if (f_q.rden | f_q.wren) begin
          b_d.tag = f_q.tag;
          b_d.idx = f_q.idx;
          b_d.wsel = f_q.wsel;
          b_d.wdata = f_q.wdata;
          b_d.wstrb = f_q.wstrb;
          b_d.store = f_q.wren;
          if (!lock_rdata) begin
            b_d.state = s_miss;
            b_d.cnt = '0;
          end else if (tag_rdata != f_q.tag) begin
            b_d.state = s_bypass; // Another line owns this index.
          end else if (f_q.wren) begin
            b_d.line = merge_word(line_rdata, f_q.wsel, f_q.wdata, f_q.wstrb);
            b_d.state = s_update;
            wen = 1'b1;
            waddr = f_q.idx;
          end else begin
            dtim_rsp.ready = 1'b1;
            dtim_rsp.rdata = line_rdata[f_q.wsel];
          end
        end
      end

      s_miss: begin
        dmem_req.valid = 1'b1;
        if (dmem_rsp.ready) begin
          b_d.line[b_q.cnt] = dmem_rsp.rdata;
          if (b_q.cnt == '1) begin
            // A store miss allocates the line with its bytes merged in.
            if (b_q.store) begin
              b_d.line = merge_word(b_d.line, b_q.wsel, b_q.wdata, b_q.wstrb);
            end
            wen = 1'b1;
            b_d.state = s_update;
          end else begin
            b_d.cnt = b_q.cnt + 1'b1;
          end
        end
      end

      s_bypass: begin
        dmem_req.valid = 1'b1;
        dmem_req.addr = {b_q.tag, b_q.idx, b_q.wsel, 2'b00};
        dmem_req.wstrb = b_q.wstrb;
        if (dmem_rsp.ready) begin
          dtim_rsp.ready = 1'b1;
          dtim_rsp.rdata = dmem_rsp.rdata;
          b_d.state = s_idle;
        end
      end

      s_update: begin
        dtim_rsp.ready = 1'b1;
        dtim_rsp.rdata = b_q.line[b_q.wsel];
        b_d.state = s_idle;
      end

      s_fence: begin
        // One lock bit is cleared per cycle.
        clear = 1'b1;
        if (b_q.idx == '1) begin
          dtim_rsp.ready = 1'b1;
          b_d.state = s_idle;
        end else begin
          b_d.idx = b_q.idx + 1'b1;
        end
      end

      default: begin
        b_d.state = s_idle;
      end
    endcase

    tag_wen = wen;
    line_wen = wen;
    lock_wen = wen | clear;
    tag_wdata = b_d.tag;
    line_wdata = b_d.line;
    lock_wdata = ~clear;
  end

  always_ff @(posedge clk) begin
    f_q <= f_d;
    b_q <= b_d;
    if (!rst) begin
      f_q.fence <= 1'b0;
      f_q.rden <= 1'b0;
      f_q.wren <= 1'b0;
      b_q.state <= s_idle;
    end
  end

endmodule

// File: design/dtim.sv
`timescale 1ns/1ps

module dtim import dtim_pkg::*; (
  input logic clk,
  input logic rst,
  input mem_req_t dtim_req,
  output mem_rsp_t dtim_rsp,
  output mem_req_t dmem_req,
  input mem_rsp_t dmem_rsp
);

  logic tag_wen;
  logic line_wen;
  logic lock_wen;
  idx_t raddr;
  idx_t waddr;
  tag_t tag_wdata;
  tag_t tag_rdata;
  line_t line_wdata;
  line_t line_rdata;
  lock_t lock_wdata;
  lock_t lock_rdata;

  dtim_array #(.entry_t(tag_t)) tag_array_i (
    .clk(clk),
    .wen(tag_wen),
    .waddr(waddr),
    .raddr(raddr),
    .wdata(tag_wdata),
    .rdata(tag_rdata)
  );

  dtim_array #(.entry_t(line_t)) line_array_i (
    .clk(clk),
    .wen(line_wen),
    .waddr(waddr),
    .raddr(raddr),
    .wdata(line_wdata),
    .rdata(line_rdata)
  );

  // A set lock bit marks the line as present.
  dtim_array #(.entry_t(lock_t)) lock_array_i (
    .clk(clk),
    .wen(lock_wen),
    .waddr(waddr),
    .raddr(raddr),
    .wdata(lock_wdata),
    .rdata(lock_rdata)
  );

  dtim_ctrl ctrl_i (
    .clk(clk),
    .rst(rst),
    .dtim_req(dtim_req),
    .dtim_rsp(dtim_rsp),
    .dmem_req(dmem_req),
    .dmem_rsp(dmem_rsp),
    .tag_wen(tag_wen),
    .line_wen(line_wen),
    .lock_wen(lock_wen),
    .raddr(raddr),
    .waddr(waddr),
    .tag_wdata(tag_wdata),
    .line_wdata(line_wdata),
    .lock_wdata(lock_wdata),
    .tag_rdata(tag_rdata),
    .line_rdata(line_rdata),
    .lock_rdata(lock_rdata)
  );

endmodule

// File: tests/dmem_model.sv
`timescale 1ns/1ps

// Data memory that answers each beat a fixed number of cycles after valid.
module dmem_model import dtim_pkg::*; #(
  parameter int LATENCY = 2,
  parameter logic [31:0] FILL_XOR = 32'h0000_0000
) (
  input logic clk,
  input logic rst,
  input mem_req_t req,
  output mem_rsp_t rsp
);

  logic [31:0] mem [logic [31:0]]; // Holds only the words that were written.
  int wait_cnt = 0;

  initial begin
    rsp = '0;
  end

  // A word never written reads as its own address mixed with a fixed pattern.
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] word;
    word = addr ^ FILL_XOR;
    if (mem.exists(addr)) begin
      word = mem[addr];
    end
    return word;
  endfunction

  always @(posedge clk) begin : beat
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] mask;
    addr = {req.addr[31:2], 2'b00};
    mask = {{8{req.wstrb[3]}}, {8{req.wstrb[2]}}, {8{req.wstrb[1]}}, {8{req.wstrb[0]}}};
    if (!rst) begin
      rsp <= '0;
      wait_cnt <= 0;
    end else if (rsp.ready) begin
      rsp.ready <= 1'b0; // The beat was taken on this edge.
    end else if (req.valid) begin
      if (wait_cnt >= LATENCY - 1) begin
        // A store answers with the word as it stands after the write.
        word = (read_word(addr) & ~mask) | (req.wdata & mask);
        if (req.wstrb != '0) begin
          mem[addr] = word;
        end
        rsp.ready <= 1'b1;
        rsp.rdata <= word;
        wait_cnt <= 0;
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

endmodule

// File: tests/dtim_tb.sv
`timescale 1ns/1ps
`include "dtim_defines.svh"

module dtim_tb import dtim_pkg::*; ();

  localparam int DMEM_LATENCY = 2;
  localparam logic [31:0] FILL_XOR = 32'h5a00_f00f;
  localparam int WORDS = `DTIM_WORDS;
  localparam int FENCE_CYCLES = (1 << `DTIM_DEPTH) + 1;
  localparam logic [31:0] A_LINE = 32'h0000_1040; // Index 4.
  localparam logic [31:0] A_CONFLICT = 32'h0000_2040; // Index 4 with another tag.
  localparam logic [31:0] A_OTHER = 32'h0000_3080; // Index 8.

  typedef enum logic [1:0] {
    op_read,
    op_store,
    op_fence
  } op_t;

  typedef struct packed {
    op_t op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic [31:0] rdata;
    logic [7:0] cycles; // Zero where the latency depends on memory.
    logic [3:0] beats;
  } row_t;

  logic clk;
  logic rst;
  mem_req_t dtim_req;
  mem_rsp_t dtim_rsp;
  mem_req_t dmem_req;
  mem_rsp_t dmem_rsp;

  row_t rows [$];
  string names [$];
  mem_req_t beats_q [$];
  int dmem_cycles;
  int timeout_limit;
  int cycle_cnt = 0;

  dtim dtim_i (
    .clk(clk),
    .rst(rst),
    .dtim_req(dtim_req),
    .dtim_rsp(dtim_rsp),
    .dmem_req(dmem_req),
    .dmem_rsp(dmem_rsp)
  );

  dmem_model #(.LATENCY(DMEM_LATENCY), .FILL_XOR(FILL_XOR)) dmem_i (
    .clk(clk),
    .rst(rst),
    .req(dmem_req),
    .rsp(dmem_rsp)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ FILL_XOR;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic string req_text(input mem_req_t req);
    return $sformatf("v=%0b f=%0b a=%h s=%h d=%h", req.valid, req.fence, req.addr, req.wstrb,
                     req.wdata);
  endfunction

  task automatic add_row(input string name, input op_t op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] wstrb,
                         input logic [31:0] rdata, input int cycles, input int beats);
    row_t row;
    row.op = op;
    row.addr = addr;
    row.wdata = wdata;
    row.wstrb = wstrb;
    row.rdata = rdata;
    row.cycles = 8'(cycles);
    row.beats = 4'(beats);
    rows.push_back(row);
    names.push_back(name);
  endtask

  task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act,
                           input logic with_data);
    if (act.ready !== exp.ready || (with_data && act.rdata !== exp.rdata)) begin
      $display("[FAIL] %s: expected ready=%0b rdata=%h, actual ready=%0b rdata=%h",
               name, exp.ready, exp.rdata, act.ready, act.rdata);
      $display("** FAIL **");
      $fatal(1, "Core response mismatch.");
    end
  endtask

  task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
    logic bad;
    bad = act.valid !== exp.valid || act.fence !== exp.fence || act.addr !== exp.addr ||
          act.wstrb !== exp.wstrb;
    if (exp.wstrb != '0 && act.wdata !== exp.wdata) begin
      bad = 1'b1; // Write data matters only on a store beat.
    end
    if (bad) begin
      $display("[FAIL] %s: expected %s, actual %s", name, req_text(exp), req_text(act));
      $display("** FAIL **");
      $fatal(1, "Data memory request mismatch.");
    end
  endtask

  task automatic expect_count(input string name, input string what, input int exp,
                              input int act);
    if (act != exp) begin
      $display("[FAIL] %s: %s expected %0d, actual %0d", name, what, exp, act);
      $display("** FAIL **");
      $fatal(1, "Count mismatch.");
    end
  endtask

  // Records every accepted beat on the memory side.
  always @(negedge clk) begin
    if (dmem_req.valid === 1'b1) begin
      dmem_cycles++;
      if (dmem_rsp.ready === 1'b1) begin
        beats_q.push_back(dmem_req);
      end
    end
  end

  always @(posedge clk) begin
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", timeout_limit);
      $display("** FAIL **");
      $fatal(1, "Timeout.");
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  initial begin
    mem_rsp_t exp_rsp;
    mem_rsp_t rsp_seen;
    mem_req_t exp_req;
    logic dmem_ready_seen;
    int cycles;
    logic [31:0] line_base;
    logic [31:0] hit_word;
    logic [31:0] miss_word;
    logic [31:0] byp_word;
    clk = 1'b0;
    rst = 1'b0;
    dtim_req = '0;
    dmem_cycles = 0;
    hit_word = merge_bytes(mem_word(A_LINE + 8), 32'h1122_3344, 4'b0110);
    miss_word = merge_bytes(mem_word(A_OTHER + 12), 32'hdead_beef, 4'b1001);
    byp_word = merge_bytes(mem_word(A_CONFLICT + 4), 32'hcafe_f00d, 4'b0011);
    add_row("read miss", op_read, A_LINE + 8, '0, 4'h0, mem_word(A_LINE + 8), 0, WORDS);
    add_row("read hit", op_read, A_LINE + 4, '0, 4'h0, mem_word(A_LINE + 4), 1, 0);
    add_row("store hit", op_store, A_LINE + 8, 32'h1122_3344, 4'b0110, hit_word, 2, 0);
    add_row("read merged hit", op_read, A_LINE + 8, '0, 4'h0, hit_word, 1, 0);
    add_row("store miss", op_store, A_OTHER + 12, 32'hdead_beef, 4'b1001, miss_word, 0, WORDS);
    add_row("read merged miss", op_read, A_OTHER + 12, '0, 4'h0, miss_word, 1, 0);
    add_row("read filled word", op_read, A_OTHER, '0, 4'h0, mem_word(A_OTHER), 1, 0);
    add_row("bypass read", op_read, A_CONFLICT + 8, '0, 4'h0, mem_word(A_CONFLICT + 8), 0, 1);
    add_row("bypass store", op_store, A_CONFLICT + 4, 32'hcafe_f00d, 4'b0011, byp_word, 0, 1);
    add_row("bypass read back", op_read, A_CONFLICT + 4, '0, 4'h0, byp_word, 0, 1);
    add_row("line kept", op_read, A_LINE + 8, '0, 4'h0, hit_word, 1, 0);
    add_row("fence", op_fence, '0, '0, 4'h0, '0, FENCE_CYCLES, 0);
    add_row("refetch line", op_read, A_LINE + 8, '0, 4'h0, mem_word(A_LINE + 8), 0, WORDS);
    add_row("refetch other", op_read, A_OTHER + 12, '0, 4'h0, mem_word(A_OTHER + 12), 0, WORDS);
    add_row("hit after refetch", op_read, A_OTHER + 12, '0, 4'h0, mem_word(A_OTHER + 12), 1, 0);
    timeout_limit = 200 * rows.size();

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    @(negedge clk);
    exp_rsp = '0;
    check_rsp("reset", exp_rsp, dtim_rsp, 1'b0);
    expect_count("reset", "dmem valid", 0, int'(dmem_req.valid));

    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      beats_q.delete();
      dmem_cycles = 0;
      dtim_req.valid = 1'b1;
      dtim_req.fence = (rows[i].op == op_fence);
      dtim_req.addr = rows[i].addr;
      dtim_req.wdata = rows[i].wdata;
      dtim_req.wstrb = rows[i].wstrb;
      @(posedge clk);
      #1;
      dtim_req = '0;
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
      end while (dtim_rsp.ready !== 1'b1);
      rsp_seen = dtim_rsp;
      dmem_ready_seen = dmem_rsp.ready;
      @(posedge clk);
      exp_rsp.ready = 1'b1;
      exp_rsp.rdata = rows[i].rdata;
      check_rsp(names[i], exp_rsp, rsp_seen, rows[i].op != op_fence);
      if (rows[i].cycles != 0) begin
        expect_count(names[i], "cycles to ready", int'(rows[i].cycles), cycles);
      end
      // A bypass answers in the cycle memory does, a fill ends one cycle after its last beat.
      expect_count(names[i], "dmem ready with core ready", int'(rows[i].beats == 1),
                   int'(dmem_ready_seen));
      expect_count(names[i], "dmem beats", int'(rows[i].beats), beats_q.size());
      if (rows[i].beats == 0) begin
        expect_count(names[i], "dmem valid cycles", 0, dmem_cycles);
      end
      line_base = {rows[i].addr[31:`DTIM_WIDTH+2], {(`DTIM_WIDTH+2){1'b0}}};
      foreach (beats_q[k]) begin
        exp_req.valid = 1'b1;
        exp_req.fence = 1'b0;
        exp_req.wdata = rows[i].wdata;
        if (rows[i].beats == 1) begin
          exp_req.addr = {rows[i].addr[31:2], 2'b00}; // A single bypass beat.
          exp_req.wstrb = rows[i].wstrb;
        end else begin
          exp_req.addr = line_base + 32'(4 * k);
          exp_req.wstrb = '0;
        end
        check_req(names[i], exp_req, beats_q[k]);
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// File: src.f
+incdir+design
design/dtim_pkg.sv
design/dtim_array.sv
design/dtim_ctrl.sv
design/dtim.sv
tests/dmem_model.sv
tests/dtim_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dtim_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
